//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP = camera_tb
FILE_LIST = compile.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- common/camera_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, stream and buffer request types, opcodes
// Imported by every block of the camera capture subsystem
////////////////////////////////////////////////////////////

package camera_pkg;

    parameter int pixel_width = 10;          // Raw Bayer sample
    parameter int buffer_address_width = 12; // Up to 4096 image bytes

    // Status byte layout, upper bits read as zero
    parameter int status_image_ready_bit = 0;
    parameter int status_capture_busy_bit = 1;

    // Byte-to-pixel style stream, plain levels
    typedef struct packed {
        logic frame_valid;
        logic line_valid;
        logic [pixel_width-1:0] data;
    } pixel_stream_t;

    // One access toward the image buffer arbiter
    typedef struct packed {
        logic request;
        logic write; // Low for a read
        logic [buffer_address_width-1:0] address;
        logic [7:0] data;
    } buffer_request_t;

    typedef enum logic [7:0] {
        op_start_capture = 8'h20,
        op_read_status = 8'h21,
        op_read_metering = 8'h22,
        op_read_image = 8'h23,
        op_reset_read_address = 8'h24
    } camera_opcode_t;

endpackage

//--- compile.f
common/camera_pkg.sv
source/pixel_crop.sv
source/frame_metering.sv
image_buffer/buffer_writer.sv
image_buffer/image_buffer.sv
source/camera_registers.sv
source/camera_top.sv
tests/camera_clock_gen.sv
tests/camera_asserts.sv
tests/camera_tb.sv

//--- image_buffer/buffer_writer.sv
////////////////////////////////////////////////////////////
// Writes one cropped frame into the image buffer per start
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module buffer_writer (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input camera_pkg::pixel_stream_t pixel_stream_i,
    input logic start_capture_i,
    input logic grant_i,
    output camera_pkg::buffer_request_t request_o,
    output logic image_ready_o,
    output logic capture_busy_o
);

    import camera_pkg::*;

    typedef enum logic [1:0] {
        idle,
        armed,    // Waiting for the next frame start
        capturing
    } writer_state_t;

    writer_state_t state;
    logic frame_valid_d;
    logic frame_rise;
    logic frame_fall;
    logic [buffer_address_width-1:0] write_address;

    assign frame_rise = pixel_stream_i.frame_valid && !frame_valid_d;
    assign frame_fall = frame_valid_d && !pixel_stream_i.frame_valid;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state <= idle;
            frame_valid_d <= 1'b0;
            write_address <= '0;
            image_ready_o <= 1'b0;
        end else begin
            frame_valid_d <= pixel_stream_i.frame_valid;

            case (state)
                idle: begin
                    if (start_capture_i) state <= armed;
                end
                armed: begin
                    if (frame_rise) begin
                        state <= capturing;
                        image_ready_o <= 1'b0; // Old image is about to be overwritten
                        write_address <= '0;
                    end
                end
                capturing: begin
                    if (request_o.request && grant_i) write_address <= write_address + 1'b1;
                    if (frame_fall) begin
                        state <= idle;
                        image_ready_o <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    assign capture_busy_o = (state == capturing);

    // Upper 8 bits of each window pixel
    always_comb begin
        request_o.request = (state == capturing) && pixel_stream_i.line_valid;
        request_o.write = 1'b1;
        request_o.address = write_address;
        request_o.data = pixel_stream_i.data[pixel_width-1 -: 8];
    end

endmodule

//--- image_buffer/image_buffer.sv
////////////////////////////////////////////////////////////
// Byte image memory shared by writer and register reader
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module image_buffer #(
    parameter int depth = 4096
) (
    input logic mipi_byte_clock,
    input camera_pkg::buffer_request_t writer_request_i,
    input camera_pkg::buffer_request_t reader_request_i,
    output logic writer_grant_o,
    output logic reader_grant_o,
    output logic [7:0] read_data_o
);

    import camera_pkg::*;

    localparam int index_width = $clog2(depth);

    logic [7:0] memory [depth];
    buffer_request_t selected;
    logic [index_width-1:0] index;

    // Fixed priority, the writer is never stalled
    assign writer_grant_o = writer_request_i.request;
    assign reader_grant_o = reader_request_i.request && !writer_request_i.request;

    assign selected = writer_grant_o ? writer_request_i : reader_request_i;
    assign index = selected.address[index_width-1:0];

    // Single port, read data registered
    always_ff @(posedge mipi_byte_clock) begin
        if (selected.request) begin
            if (selected.write) memory[index] <= selected.data;
            else read_data_o <= memory[index];
        end
    end

endmodule

//--- source/camera_registers.sv
////////////////////////////////////////////////////////////
// Opcode register block for capture control and readback
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module camera_registers (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input logic [7:0] opcode_i,
    input logic opcode_valid_i,
    input logic [7:0] metering_i,
    input logic metering_ready_i,
    input logic image_ready_i,
    input logic capture_busy_i,
    input logic grant_i,
    input logic [7:0] read_data_i,
    output camera_pkg::buffer_request_t request_o,
    output logic start_capture_o,
    output logic [7:0] response_o,
    output logic response_valid_o
);

    import camera_pkg::*;

    typedef enum logic [1:0] {
        idle,
        read_wait, // Lost arbitration to the writer
        read_data  // Buffer data arrives this cycle
    } read_state_t;

    read_state_t state;
    logic [7:0] metering_value;
    logic [7:0] status_byte;
    logic [buffer_address_width-1:0] read_address;
    logic read_start;

    assign read_start = (state == idle) && opcode_valid_i && (opcode_i == op_read_image);

    always_comb begin
        status_byte = '0;
        status_byte[status_image_ready_bit] = image_ready_i;
        status_byte[status_capture_busy_bit] = capture_busy_i;
    end

    // Read request goes out in the strobe cycle already
    always_comb begin
        request_o.request = read_start || (state == read_wait);
        request_o.write = 1'b0;
        request_o.address = read_address;
        request_o.data = '0;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state <= idle;
            metering_value <= '0;
            read_address <= '0;
            start_capture_o <= 1'b0;
            response_valid_o <= 1'b0;
        end else begin
            start_capture_o <= 1'b0;
            response_valid_o <= 1'b0;

            if (metering_ready_i) metering_value <= metering_i;

            case (state)
                idle: begin
                    if (opcode_valid_i) begin
                        case (camera_opcode_t'(opcode_i))
                            op_start_capture: start_capture_o <= 1'b1;
                            op_read_status: response_valid_o <= 1'b1;
                            op_read_metering: response_valid_o <= 1'b1;
                            op_read_image: state <= grant_i ? read_data : read_wait;
                            op_reset_read_address: read_address <= '0;
                            default: ; // Unknown opcodes do nothing
                        endcase
                    end
                end
                read_wait: begin
                    if (grant_i) state <= read_data;
                end
                read_data: begin
                    response_valid_o <= 1'b1;
                    read_address <= read_address + 1'b1;
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // Response byte, qualified by response_valid_o
    always_ff @(posedge mipi_byte_clock) begin
        if (state == read_data) begin
            response_o <= read_data_i;
        end else if (opcode_valid_i && state == idle) begin
            if (opcode_i == op_read_status) response_o <= status_byte;
            if (opcode_i == op_read_metering) response_o <= metering_value;
        end
    end

endmodule

//--- source/camera_top.sv
////////////////////////////////////////////////////////////
// Camera capture top, crop window set by the parameters
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module camera_top #(
    parameter int x_start = 4,
    parameter int y_start = 2,
    parameter int crop_width = 8,
    parameter int crop_height = 8
) (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input camera_pkg::pixel_stream_t pixel_stream_i,
    input logic [7:0] opcode_i,
    input logic opcode_valid_i,
    output logic [7:0] response_o,
    output logic response_valid_o
);

    import camera_pkg::*;

    pixel_stream_t cropped_stream;
    logic [7:0] metering;
    logic metering_ready;
    logic start_capture;
    logic image_ready;
    logic capture_busy;
    buffer_request_t writer_request;
    buffer_request_t reader_request;
    logic writer_grant;
    logic reader_grant;
    logic [7:0] read_data;

    pixel_crop #(
        .x_start(x_start),
        .y_start(y_start),
        .crop_width(crop_width),
        .crop_height(crop_height)
    ) u_pixel_crop (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_stream_i(pixel_stream_i),
        .pixel_stream_o(cropped_stream)
    );

    frame_metering #(
        .crop_width(crop_width),
        .crop_height(crop_height)
    ) u_frame_metering (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_stream_i(cropped_stream),
        .metering_o(metering),
        .metering_ready_o(metering_ready)
    );

    buffer_writer u_buffer_writer (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_stream_i(cropped_stream),
        .start_capture_i(start_capture),
        .grant_i(writer_grant),
        .request_o(writer_request),
        .image_ready_o(image_ready),
        .capture_busy_o(capture_busy)
    );

    // One byte per window pixel
    image_buffer #(
        .depth(crop_width * crop_height)
    ) u_image_buffer (
        .mipi_byte_clock(mipi_byte_clock),
        .writer_request_i(writer_request),
        .reader_request_i(reader_request),
        .writer_grant_o(writer_grant),
        .reader_grant_o(reader_grant),
        .read_data_o(read_data)
    );

    camera_registers u_camera_registers (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .opcode_i(opcode_i),
        .opcode_valid_i(opcode_valid_i),
        .metering_i(metering),
        .metering_ready_i(metering_ready),
        .image_ready_i(image_ready),
        .capture_busy_i(capture_busy),
        .grant_i(reader_grant),
        .read_data_i(read_data),
        .request_o(reader_request),
        .start_capture_o(start_capture),
        .response_o(response_o),
        .response_valid_o(response_valid_o)
    );

endmodule

//--- source/frame_metering.sv
////////////////////////////////////////////////////////////
// Mean brightness of the cropped window, updated per frame
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module frame_metering #(
    parameter int crop_width = 8,  // Power of two
    parameter int crop_height = 8  // Power of two
) (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input camera_pkg::pixel_stream_t pixel_stream_i,
    output logic [7:0] metering_o,
    output logic metering_ready_o
);

    import camera_pkg::*;

    localparam int shift = $clog2(crop_width * crop_height);
    localparam int sum_width = 8 + shift;

    logic [sum_width-1:0] sum;
    logic frame_valid_d;
    logic frame_fall;

    assign frame_fall = frame_valid_d && !pixel_stream_i.frame_valid;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            sum <= '0;
            frame_valid_d <= 1'b0;
            metering_ready_o <= 1'b0;
        end else begin
            frame_valid_d <= pixel_stream_i.frame_valid;
            metering_ready_o <= frame_fall;

            if (frame_fall) begin
                sum <= '0;
            end else if (pixel_stream_i.line_valid) begin
                sum <= sum + sum_width'(pixel_stream_i.data[pixel_width-1 -: 8]);
            end
        end
    end

    // Divide by the window area, floor of the mean
    always_ff @(posedge mipi_byte_clock) begin
        if (frame_fall) metering_o <= sum[shift +: 8];
    end

endmodule

//--- source/pixel_crop.sv
////////////////////////////////////////////////////////////
// Fixed window crop of the raw pixel stream, one cycle delay
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pixel_crop #(
    parameter int x_start = 0,
    parameter int y_start = 0,
    parameter int crop_width = 8,
    parameter int crop_height = 8
) (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input camera_pkg::pixel_stream_t pixel_stream_i,
    output camera_pkg::pixel_stream_t pixel_stream_o
);

    localparam logic [15:0] x_first = 16'(x_start);
    localparam logic [15:0] x_last = 16'(x_start + crop_width);
    localparam logic [15:0] y_first = 16'(y_start);
    localparam logic [15:0] y_last = 16'(y_start + crop_height);

    logic [15:0] x_count; // Pixel within the current line
    logic [15:0] y_count; // Line within the current frame
    logic [15:0] y_now;
    logic line_valid_d;
    logic frame_valid_d;
    logic frame_rise;
    logic line_fall;
    logic in_window;

    assign frame_rise = pixel_stream_i.frame_valid && !frame_valid_d;
    assign line_fall = line_valid_d && !pixel_stream_i.line_valid;

    // A line may start together with the frame
    assign y_now = frame_rise ? '0 : y_count;

    assign in_window = pixel_stream_i.line_valid &&
                       x_count >= x_first && x_count < x_last &&
                       y_now >= y_first && y_now < y_last;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_d <= 1'b0;
            frame_valid_d <= 1'b0;
            pixel_stream_o <= '0;
        end else begin
            line_valid_d <= pixel_stream_i.line_valid;
            frame_valid_d <= pixel_stream_i.frame_valid;

            if (pixel_stream_i.line_valid) x_count <= x_count + 1'b1;
            else x_count <= '0;

            if (frame_rise) y_count <= '0;
            else if (line_fall) y_count <= y_count + 1'b1;

            pixel_stream_o.frame_valid <= pixel_stream_i.frame_valid;
            pixel_stream_o.line_valid <= in_window;
            pixel_stream_o.data <= pixel_stream_i.data;
        end
    end

endmodule

//--- tests/camera_asserts.sv
////////////////////////////////////////////////////////////
// Concurrent checks on camera_top internals, bound from here
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module camera_asserts (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input logic writer_grant_i,
    input logic reader_grant_i,
    input logic response_valid_i,
    input logic image_ready_i,
    input logic capture_busy_i
);

    int failure_count = 0; // Read by the testbench at the end

    grant_exclusive: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        !(writer_grant_i && reader_grant_i))
        else begin
            failure_count++;
            $error("Writer and reader grants are high together");
        end

    // Response strobe is a single-cycle pulse
    response_pulse: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        response_valid_i |=> !response_valid_i)
        else begin
            failure_count++;
            $error("response_valid_o stayed high for more than one cycle");
        end

    ready_busy_exclusive: assert property (@(posedge mipi_byte_clock)
        disable iff (!mipi_byte_reset_n) !(image_ready_i && capture_busy_i))
        else begin
            failure_count++;
            $error("image_ready and capture_busy are high together");
        end

endmodule

bind camera_top camera_asserts u_camera_asserts (
    .mipi_byte_clock(mipi_byte_clock),
    .mipi_byte_reset_n(mipi_byte_reset_n),
    .writer_grant_i(writer_grant),
    .reader_grant_i(reader_grant),
    .response_valid_i(response_valid_o),
    .image_ready_i(image_ready),
    .capture_busy_i(capture_busy)
);

//--- tests/camera_clock_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset for the camera capture tests
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module camera_clock_gen #(
    parameter int period = 40,     // ns
    parameter int reset_cycles = 3
) (
    output logic mipi_byte_clock_o,
    output logic mipi_byte_reset_n_o
);

    initial begin
        mipi_byte_clock_o = 1'b0;
        forever #(period / 2) mipi_byte_clock_o = ~mipi_byte_clock_o;
    end

    initial begin
        mipi_byte_reset_n_o = 1'b0;
        repeat (reset_cycles) @(posedge mipi_byte_clock_o);
        mipi_byte_reset_n_o <= 1'b1; // Released on a rising edge
    end

endmodule

//--- tests/camera_tb.sv
////////////////////////////////////////////////////////////
// Directed tests of camera_top with frames, opcodes and readback
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module camera_tb;

    import camera_pkg::*;

    localparam int clock_period = 40;
    localparam int frame_width = 16;
    localparam int frame_height = 12;
    localparam int line_cycles = frame_width + 4;              // Pixels plus line blanking
    localparam int frame_cycles = 2 + frame_height * line_cycles + 8;
    localparam int frames_sent = 4;
    localparam int watchdog_cycles = frames_sent * frame_cycles * 2;
    localparam int window_size = 64;                           // 8 by 8 window at x 4 and y 2

    logic mipi_byte_clock;
    logic mipi_byte_reset_n;
    pixel_stream_t pixel_stream_i;
    logic [7:0] opcode_i;
    logic opcode_valid_i;
    logic [7:0] response_o;
    logic response_valid_o;

    logic [31:0] lcg_state = 32'h818ba3b0;
    logic [9:0] frame_pixels [frame_width * frame_height]; // Reference copy of the last frame
    logic [7:0] expected_image [window_size];
    int error_count = 0;

    camera_clock_gen #(.period(clock_period), .reset_cycles(3)) u_camera_clock_gen (
        .mipi_byte_clock_o(mipi_byte_clock),
        .mipi_byte_reset_n_o(mipi_byte_reset_n)
    );

    camera_top #(.x_start(4), .y_start(2), .crop_width(8), .crop_height(8)) u_camera_top (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_stream_i(pixel_stream_i),
        .opcode_i(opcode_i),
        .opcode_valid_i(opcode_valid_i),
        .response_o(response_o),
        .response_valid_o(response_valid_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fill_frame();
        for (int i = 0; i < frame_width * frame_height; i++) begin
            lcg_state = lcg_next(lcg_state);
            frame_pixels[i] = lcg_state[25:16];
        end
    endtask

    // Stored byte of a window pixel in raster order
    function automatic logic [7:0] window_byte(input int index);
        logic [9:0] pixel;
        pixel = frame_pixels[(2 + index / 8) * frame_width + 4 + index % 8];
        return pixel[9:2];
    endfunction

    function automatic logic [7:0] window_mean();
        int sum;
        sum = 0;
        for (int i = 0; i < window_size; i++) sum += int'(window_byte(i));
        return 8'(sum / window_size); // Floor of the mean
    endfunction

    task automatic store_expected_image();
        for (int i = 0; i < window_size; i++) expected_image[i] = window_byte(i);
    endtask

    task automatic drive_stream(input logic fv, input logic lv, input logic [9:0] data);
        @(posedge mipi_byte_clock);
        pixel_stream_i <= '{frame_valid: fv, line_valid: lv, data: data};
    endtask

    task automatic send_frame();
        repeat (2) drive_stream(1'b1, 1'b0, '0);
        for (int row = 0; row < frame_height; row++) begin
            for (int col = 0; col < frame_width; col++) begin
                drive_stream(1'b1, 1'b1, frame_pixels[row * frame_width + col]);
            end
            repeat (line_cycles - frame_width) drive_stream(1'b1, 1'b0, '0);
        end
        repeat (8) drive_stream(1'b0, 1'b0, '0); // Vertical blanking
    endtask

    task automatic send_opcode(input camera_opcode_t op);
        @(posedge mipi_byte_clock);
        opcode_i <= op;
        opcode_valid_i <= 1'b1;
        @(posedge mipi_byte_clock);
        opcode_valid_i <= 1'b0;
    endtask

    // Latency counts cycles after the strobe and is zero when nothing came
    task automatic await_response(input int limit, output int latency, output logic [7:0] data);
        bit found;
        found = 1'b0;
        latency = 0;
        data = '0;
        while (!found && latency < limit) begin
            @(negedge mipi_byte_clock);
            latency++;
            if (response_valid_o) begin
                found = 1'b1;
                data = response_o;
            end
        end
        if (!found) latency = 0;
    endtask

    task automatic read_register(input camera_opcode_t op, input logic [7:0] expected,
                                 input string name);
        int latency;
        logic [7:0] data;
        send_opcode(op);
        await_response(4, latency, data);
        if (latency == 0) begin
            error_count++;
            $display("No response arrived for the %s read", name);
        end else begin
            if (latency != 1) begin
                error_count++;
                $display("Error: response_valid_o latency for %s is %h, expected %h",
                         name, latency, 1);
            end
            if (data !== expected) begin
                error_count++;
                $display("Error: response_o for %s is %h, expected %h", name, data, expected);
            end
        end
    endtask

    task automatic read_back_image(input string label);
        int latency;
        logic [7:0] data;
        send_opcode(op_reset_read_address);
        for (int i = 0; i < window_size; i++) begin
            send_opcode(op_read_image);
            await_response(4, latency, data);
            if (latency == 0) begin
                error_count++;
                $display("Image read %0d of the %s readback got no response", i, label);
            end else begin
                if (latency != 2) begin
                    error_count++;
                    $display("Error: response_valid_o latency at byte %0d is %h, expected %h",
                             i, latency, 2);
                end
                if (data !== expected_image[i]) begin
                    error_count++;
                    $display("Error: response_o at byte %0d (%s) is %h, expected %h",
                             i, label, data, expected_image[i]);
                end
            end
        end
    endtask

    task automatic read_status_after_reset();
        read_register(op_read_status, 8'h00, "status after reset");
    endtask

    task automatic meter_uncaptured_frame();
        fill_frame();
        send_frame();
        read_register(op_read_metering, window_mean(), "metering");
    endtask

    task automatic capture_and_read_back();
        fill_frame();
        send_opcode(op_start_capture);
        send_frame();
        store_expected_image();
        read_register(op_read_status, 8'h01, "status after capture");
        read_back_image("first capture");
    endtask

    // Buffer keeps the first image while the writer is idle
    task automatic keep_image_when_unarmed();
        fill_frame();
        send_frame();
        read_back_image("unarmed frame");
    endtask

    task automatic read_during_capture();
        int latency;
        logic [7:0] data;
        fill_frame();
        send_opcode(op_start_capture);
        fork
            send_frame();
            begin
                repeat (2 * line_cycles) @(posedge mipi_byte_clock); // Into the window rows
                for (int i = 0; i < 24; i++) begin
                    send_opcode(op_read_image);
                    await_response(line_cycles, latency, data);
                    if (latency == 0) begin
                        error_count++;
                        $display("Image read %0d during capture took longer than a line", i);
                    end
                end
            end
        join
        store_expected_image();
        read_register(op_read_status, 8'h01, "status after second capture");
        read_back_image("second capture");
    endtask

    initial begin
        pixel_stream_i = '0;
        opcode_i = '0;
        opcode_valid_i = 1'b0;
        @(posedge mipi_byte_reset_n);
        repeat (2) @(posedge mipi_byte_clock);
        read_status_after_reset();
        meter_uncaptured_frame();
        capture_and_read_back();
        keep_image_when_unarmed();
        read_during_capture();
        if (u_camera_top.u_camera_asserts.failure_count != 0) begin
            error_count++;
            $display("Bound assertions failed %0d times",
                     u_camera_top.u_camera_asserts.failure_count);
        end
        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_cycles * clock_period);
        $display("Timeout after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule
